//--- Makefile
# Verilator build and run of the squeeze_io testbench

VERILATOR ?= verilator
TOP       ?= tb_squeeze_io
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= TESTS PASSED
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

# run the simulation and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit $$status; fi; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/block_dma.sv
`timescale 1ns/1ps
`default_nettype none

module block_dma #(
	parameter int MEM_WORDS = squeeze_io_pkg::MEM_WORDS
) (
	input  wire                          okClk,
	input  wire                          reset,
	input  wire                          fifo_reset,
	input  wire                          writes_en,    // enables fifo to store
	input  wire                          reads_en,     // enables store to destination
	// input fifo
	output logic                         ib_re,
	input  wire squeeze_io_pkg::word_t   ib_data,
	input  wire squeeze_io_pkg::count_t  ib_count,
	// routed destination
	output logic                         ob_we,
	output squeeze_io_pkg::word_t        ob_data,
	input  wire squeeze_io_pkg::count_t  ob_count,
	output logic                         busy,
	// word store
	output logic                         mem_wr_en,
	output logic [$clog2(MEM_WORDS)-1:0] mem_wr_addr,
	output squeeze_io_pkg::word_t        mem_wr_data,
	output logic                         mem_rd_en,
	output logic [$clog2(MEM_WORDS)-1:0] mem_rd_addr,
	input  wire squeeze_io_pkg::word_t   mem_rd_data
);

	localparam int AW = $clog2(MEM_WORDS);
	localparam int BW = $clog2(squeeze_io_pkg::BLOCK_SIZE);

	localparam logic [BW-1:0] LAST_BEAT  = BW'(squeeze_io_pkg::BLOCK_SIZE - 1);
	localparam logic [AW:0]   BLOCK_FILL = (AW+1)'(squeeze_io_pkg::BLOCK_SIZE);
	localparam logic [AW:0]   ROOM_LIMIT = (AW+1)'(MEM_WORDS - squeeze_io_pkg::BLOCK_SIZE);

	localparam squeeze_io_pkg::count_t IB_NEED =
		squeeze_io_pkg::count_t'(squeeze_io_pkg::BLOCK_SIZE);
	localparam squeeze_io_pkg::count_t OB_LIMIT =
		squeeze_io_pkg::count_t'(squeeze_io_pkg::FIFO_DEPTH - squeeze_io_pkg::BLOCK_SIZE);

	logic          clr;
	logic          wr_active;
	logic [BW-1:0] wr_beat;
	logic [AW-1:0] wr_addr;
	logic          wr_start;
	logic          rd_active;
	logic [BW-1:0] rd_beat;
	logic [AW-1:0] rd_addr;
	logic          rd_start;
	logic [AW:0]   stored;     // words in the store not yet read back

	function automatic logic [AW-1:0] next_addr(input logic [AW-1:0] a);
		return (a == AW'(MEM_WORDS - 1)) ? '0 : a + 1'b1;
	endfunction

	assign clr = reset || fifo_reset;

	// ------------------------------------------------------------
	// block start conditions
	// ------------------------------------------------------------
	assign wr_start = writes_en && !wr_active && (ib_count >= IB_NEED) &&
		(stored <= ROOM_LIMIT);

	// waiting out the trailing ob_we lets ob_count settle before the next check
	assign rd_start = reads_en && !rd_active && !ob_we && (stored >= BLOCK_FILL) &&
		(ob_count <= OB_LIMIT);

	// write side pops the show-ahead head and stores it in the same cycle
	assign ib_re       = wr_active;
	assign mem_wr_en   = wr_active;
	assign mem_wr_addr = wr_addr;
	assign mem_wr_data = ib_data;

	assign mem_rd_en   = rd_active;
	assign mem_rd_addr = rd_addr;
	assign ob_data     = mem_rd_data;  // lines up with ob_we

	assign busy = wr_active || rd_active || ob_we;

	// ------------------------------------------------------------
	// write side, input fifo to store
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (clr) begin
			wr_active <= 1'b0;
			wr_beat   <= '0;
			wr_addr   <= '0;
		end else if (wr_active) begin
			wr_addr <= next_addr(wr_addr);
			wr_beat <= wr_beat + 1'b1;
			if (wr_beat == LAST_BEAT) begin
				wr_active <= 1'b0;
			end
		end else if (wr_start) begin
			wr_active <= 1'b1;
			wr_beat   <= '0;
		end
	end

	// ------------------------------------------------------------
	// read side, store to destination
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (clr) begin
			rd_active <= 1'b0;
			rd_beat   <= '0;
			rd_addr   <= '0;
			ob_we     <= 1'b0;
		end else begin
			ob_we <= rd_active;  // one cycle read latency
			if (rd_active) begin
				rd_addr <= next_addr(rd_addr);
				rd_beat <= rd_beat + 1'b1;
				if (rd_beat == LAST_BEAT) begin
					rd_active <= 1'b0;
				end
			end else if (rd_start) begin
				rd_active <= 1'b1;
				rd_beat   <= '0;
			end
		end
	end

	// both sides move one word per cycle at most
	always_ff @(posedge okClk) begin
		if (clr) begin
			stored <= '0;
		end else begin
			case ({mem_wr_en, mem_rd_en})
				2'b10:   stored <= stored + 1'b1;
				2'b01:   stored <= stored - 1'b1;
				default: stored <= stored;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/dest_router.sv
`timescale 1ns/1ps
`default_nettype none

module dest_router (
	input  wire                         okClk,
	input  wire                         reset,
	input  wire                         op_en,
	input  wire                         op_run,
	input  wire                         busy,        // mover inside a block
	input  wire                         ob_we,
	input  wire squeeze_io_pkg::word_t  ob_data,
	output logic                        pipe_we,
	output squeeze_io_pkg::word_t       pipe_data,
	input  wire squeeze_io_pkg::count_t pipe_count,
	output logic                        cmd_we,
	output squeeze_io_pkg::word_t       cmd_data,
	input  wire squeeze_io_pkg::count_t cmd_count,
	output logic                        data_we,
	output squeeze_io_pkg::word_t       data_data,
	input  wire squeeze_io_pkg::count_t data_count,
	output squeeze_io_pkg::count_t      ob_count
);

	squeeze_io_pkg::route_t route_sel;  // decoded from the levels
	squeeze_io_pkg::route_t route;      // held while a block is moving
	logic                   to_pipe;
	logic                   to_cmd;
	logic                   to_data;

	assign route_sel = !op_en  ? squeeze_io_pkg::ROUTE_PIPE_OUT :
	                   !op_run ? squeeze_io_pkg::ROUTE_CMD :
	                             squeeze_io_pkg::ROUTE_DATA;

	always_ff @(posedge okClk) begin
		if (reset) begin
			route <= squeeze_io_pkg::ROUTE_PIPE_OUT;
		end else if (!busy) begin
			route <= route_sel;
		end
	end

	assign to_pipe = (route == squeeze_io_pkg::ROUTE_PIPE_OUT);
	assign to_cmd  = (route == squeeze_io_pkg::ROUTE_CMD);
	assign to_data = (route == squeeze_io_pkg::ROUTE_DATA);

	// unselected destinations see zero data
	assign pipe_we   = ob_we && to_pipe;
	assign pipe_data = to_pipe ? ob_data : '0;
	assign cmd_we    = ob_we && to_cmd;
	assign cmd_data  = to_cmd ? ob_data : '0;
	assign data_we   = ob_we && to_data;
	assign data_data = to_data ? ob_data : '0;

	// fill of the selected destination back to the mover
	assign ob_count = to_data ? data_count :
	                  to_cmd  ? cmd_count  : pipe_count;

endmodule

`default_nettype wire

//--- rtl/host_pipes.sv
`timescale 1ns/1ps
`default_nettype none

module host_pipes #(
	parameter int DEPTH = squeeze_io_pkg::FIFO_DEPTH
) (
	input  wire                        okClk,
	input  wire                        reset,
	input  wire                        fifo_reset,
	// host side
	input  wire                        pi_write,
	input  wire squeeze_io_pkg::word_t pi_data,
	output logic                       pi_ready,
	input  wire                        po_read,
	output squeeze_io_pkg::word_t      po_data,
	output logic                       po_ready,
	// mover side
	input  wire                        ib_re,
	output squeeze_io_pkg::word_t      ib_data,
	output squeeze_io_pkg::count_t     ib_count,
	input  wire                        ob_pipe_we,
	input  wire squeeze_io_pkg::word_t ob_pipe_data,
	output squeeze_io_pkg::count_t     ob_pipe_count
);

	// ------------------------------------------------------------
	// pipe fifos
	// ------------------------------------------------------------
	sync_fifo #(
		.DEPTH    (DEPTH)
	) i_pipe_in_fifo (
		.okClk    (okClk),
		.reset    (reset),
		.clear    (fifo_reset),
		.wr_en    (pi_write),       // from host
		.din      (pi_data),
		.rd_en    (ib_re),          // popped by the mover
		.dout     (ib_data),
		.empty    (),
		.full     (),
		.wr_count (ib_count)
	);

	sync_fifo #(
		.DEPTH    (DEPTH)
	) i_pipe_out_fifo (
		.okClk    (okClk),
		.reset    (reset),
		.clear    (fifo_reset),
		.wr_en    (ob_pipe_we),     // filled by the mover
		.din      (ob_pipe_data),
		.rd_en    (po_read),        // to host
		.dout     (po_data),
		.empty    (),
		.full     (),
		.wr_count (ob_pipe_count)
	);

	// ------------------------------------------------------------
	// block throttle
	// ------------------------------------------------------------
	// the host moves whole blocks, so ready only says that one more block fits
	// (pipe in) or that a whole block is waiting (pipe out)
	always_ff @(posedge okClk) begin
		if (reset || fifo_reset) begin
			pi_ready <= 1'b0;
			po_ready <= 1'b0;
		end else begin
			pi_ready <= (ib_count <= squeeze_io_pkg::count_t'(squeeze_io_pkg::PIPE_IN_LIMIT));
			po_ready <= (ob_pipe_count >= squeeze_io_pkg::count_t'(squeeze_io_pkg::BLOCK_SIZE));
		end
	end

endmodule

`default_nettype wire

//--- rtl/squeeze_io_pkg.sv
`default_nettype none

package squeeze_io_pkg;

	// ------------------------------------------------------------
	// data path types
	// ------------------------------------------------------------
	typedef logic [31:0] word_t;   // one host word
	typedef logic [10:0] count_t;  // fifo fill, 0 to 1024

	// ------------------------------------------------------------
	// block and buffer sizing
	// ------------------------------------------------------------
	localparam int FIFO_DEPTH      = 1024;
	localparam int BLOCK_SIZE      = 128;  // 512 bytes at 4 bytes per word
	localparam int BUFFER_HEADROOM = 20;   // slack for fifo count lag

	// highest pipe-in fill that still leaves room for a whole block
	localparam int PIPE_IN_LIMIT = FIFO_DEPTH - 1 - BUFFER_HEADROOM - BLOCK_SIZE;

	localparam int MEM_WORDS = 4096;  // default word store size

	// destination of the mover's read side
	typedef enum logic [1:0] {
		ROUTE_PIPE_OUT = 2'd0,  // back to the host
		ROUTE_CMD      = 2'd1,  // command fifo
		ROUTE_DATA     = 2'd2   // operand data fifo
	} route_t;

endpackage

`default_nettype wire

//--- rtl/squeeze_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module squeeze_io_top #(
	parameter int FIFO_DEPTH = squeeze_io_pkg::FIFO_DEPTH,
	parameter int MEM_WORDS  = squeeze_io_pkg::MEM_WORDS
) (
	input  wire                        okClk,
	input  wire                        reset,
	input  wire                        fifo_reset,   // pipe fifos and mover
	input  wire                        core_reset,   // command and data fifos
	input  wire                        writes_en,
	input  wire                        reads_en,
	input  wire                        op_en,
	input  wire                        op_run,
	input  wire                        pi_write,
	input  wire squeeze_io_pkg::word_t pi_data,
	output logic                       pi_ready,
	input  wire                        po_read,
	output squeeze_io_pkg::word_t      po_data,
	output logic                       po_ready,
	input  wire                        cmd_rd_en,
	output squeeze_io_pkg::word_t      cmd,
	output logic                       cmd_empty,
	input  wire                        data_rd_en,
	output squeeze_io_pkg::word_t      data_0,
	output logic                       data_empty
);

	localparam int AW = $clog2(MEM_WORDS);

	// ------------------------------------------------------------
	// internal wiring
	// ------------------------------------------------------------
	logic                   ib_re;
	squeeze_io_pkg::word_t  ib_data;
	squeeze_io_pkg::count_t ib_count;
	logic                   ob_we;
	squeeze_io_pkg::word_t  ob_data;
	squeeze_io_pkg::count_t ob_count;
	logic                   busy;

	logic                   pipe_we;
	squeeze_io_pkg::word_t  pipe_data;
	squeeze_io_pkg::count_t pipe_count;
	logic                   cmd_we;
	squeeze_io_pkg::word_t  cmd_data;
	squeeze_io_pkg::count_t cmd_count;
	logic                   data_we;
	squeeze_io_pkg::word_t  data_data;
	squeeze_io_pkg::count_t data_count;

	logic                   mem_wr_en;
	logic [AW-1:0]          mem_wr_addr;
	squeeze_io_pkg::word_t  mem_wr_data;
	logic                   mem_rd_en;
	logic [AW-1:0]          mem_rd_addr;
	squeeze_io_pkg::word_t  mem_rd_data;

	host_pipes #(
		.DEPTH         (FIFO_DEPTH)
	) i_host_pipes (
		.okClk         (okClk),
		.reset         (reset),
		.fifo_reset    (fifo_reset),
		.pi_write      (pi_write),
		.pi_data       (pi_data),
		.pi_ready      (pi_ready),
		.po_read       (po_read),
		.po_data       (po_data),
		.po_ready      (po_ready),
		.ib_re         (ib_re),
		.ib_data       (ib_data),
		.ib_count      (ib_count),
		.ob_pipe_we    (pipe_we),
		.ob_pipe_data  (pipe_data),
		.ob_pipe_count (pipe_count)
	);

	word_store #(
		.MEM_WORDS (MEM_WORDS)
	) i_word_store (
		.okClk     (okClk),
		.wr_en     (mem_wr_en),
		.wr_addr   (mem_wr_addr),
		.wr_data   (mem_wr_data),
		.rd_en     (mem_rd_en),
		.rd_addr   (mem_rd_addr),
		.rd_data   (mem_rd_data)
	);

	block_dma #(
		.MEM_WORDS   (MEM_WORDS)
	) i_block_dma (
		.okClk       (okClk),
		.reset       (reset),
		.fifo_reset  (fifo_reset),
		.writes_en   (writes_en),
		.reads_en    (reads_en),
		.ib_re       (ib_re),
		.ib_data     (ib_data),
		.ib_count    (ib_count),
		.ob_we       (ob_we),
		.ob_data     (ob_data),
		.ob_count    (ob_count),
		.busy        (busy),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.mem_rd_en   (mem_rd_en),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data)
	);

	dest_router i_dest_router (
		.okClk      (okClk),
		.reset      (reset),
		.op_en      (op_en),
		.op_run     (op_run),
		.busy       (busy),
		.ob_we      (ob_we),
		.ob_data    (ob_data),
		.pipe_we    (pipe_we),
		.pipe_data  (pipe_data),
		.pipe_count (pipe_count),
		.cmd_we     (cmd_we),
		.cmd_data   (cmd_data),
		.cmd_count  (cmd_count),
		.data_we    (data_we),
		.data_data  (data_data),
		.data_count (data_count),
		.ob_count   (ob_count)
	);

	// ------------------------------------------------------------
	// core side fifos
	// ------------------------------------------------------------
	sync_fifo #(
		.DEPTH    (FIFO_DEPTH)
	) i_cmd_fifo (
		.okClk    (okClk),
		.reset    (reset),
		.clear    (core_reset),
		.wr_en    (cmd_we),
		.din      (cmd_data),
		.rd_en    (cmd_rd_en),
		.dout     (cmd),
		.empty    (cmd_empty),
		.full     (),
		.wr_count (cmd_count)
	);

	sync_fifo #(
		.DEPTH    (FIFO_DEPTH)
	) i_data_fifo (
		.okClk    (okClk),
		.reset    (reset),
		.clear    (core_reset),
		.wr_en    (data_we),
		.din      (data_data),
		.rd_en    (data_rd_en),
		.dout     (data_0),
		.empty    (data_empty),
		.full     (),
		.wr_count (data_count)
	);

endmodule

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = squeeze_io_pkg::FIFO_DEPTH
) (
	input  wire                        okClk,
	input  wire                        reset,
	input  wire                        clear,     // same effect as reset
	input  wire                        wr_en,
	input  wire squeeze_io_pkg::word_t din,
	input  wire                        rd_en,
	output squeeze_io_pkg::word_t      dout,      // head word, show-ahead
	output logic                       empty,
	output logic                       full,
	output squeeze_io_pkg::count_t     wr_count
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	squeeze_io_pkg::word_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          push;
	logic          pop;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap at depth
	endfunction

	assign push  = wr_en && !full;   // writes into a full fifo are ignored
	assign pop   = rd_en && !empty;
	assign empty = (wr_count == '0);
	assign full  = (wr_count == squeeze_io_pkg::count_t'(DEPTH));
	assign dout  = mem[rd_ptr];

	always_ff @(posedge okClk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge okClk) begin
		if (reset || clear) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			wr_count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   wr_count <= wr_count + 1'b1;
				2'b01:   wr_count <= wr_count - 1'b1;
				default: wr_count <= wr_count;  // none, or push and pop together
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/word_store.sv
`timescale 1ns/1ps
`default_nettype none

module word_store #(
	parameter int MEM_WORDS = squeeze_io_pkg::MEM_WORDS
) (
	input  wire                         okClk,
	input  wire                         wr_en,
	input  wire [$clog2(MEM_WORDS)-1:0] wr_addr,
	input  wire squeeze_io_pkg::word_t  wr_data,
	input  wire                         rd_en,
	input  wire [$clog2(MEM_WORDS)-1:0] rd_addr,
	output squeeze_io_pkg::word_t       rd_data   // valid the cycle after rd_en
);

	squeeze_io_pkg::word_t mem [MEM_WORDS];

	// ------------------------------------------------------------
	// write port
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ------------------------------------------------------------
	// read port
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];  // held between reads
		end
	end

endmodule

`default_nettype wire

//--- verif/tb_squeeze_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_squeeze_io;

	localparam int BLOCK = squeeze_io_pkg::BLOCK_SIZE;
	localparam int N_MIN = squeeze_io_pkg::PIPE_IN_LIMIT + 1;
	localparam int N_MAX = squeeze_io_pkg::PIPE_IN_LIMIT + 5;
	localparam int TOTAL_WORDS = 4 * BLOCK + N_MAX;  // throttle fill taken at its largest
	localparam int CYCLE_LIMIT = 4 * TOTAL_WORDS + 2000;
	localparam logic [31:0] SEED = 32'hc2f9_35ac;

	logic        okClk;
	logic        reset;
	logic        fifo_reset;
	logic        core_reset;
	logic        writes_en;
	logic        reads_en;
	logic        op_en;
	logic        op_run;
	logic        pi_write;
	logic [31:0] pi_data;
	logic        pi_ready;
	logic        po_read;
	logic [31:0] po_data;
	logic        po_ready;
	logic        cmd_rd_en;
	logic [31:0] cmd;
	logic        cmd_empty;
	logic        data_rd_en;
	logic [31:0] data_0;
	logic        data_empty;

	logic [31:0] gen_state;       // stimulus generator state
	int          wr_idx = 0;      // words driven into pipe in
	int          rd_idx = 0;      // words popped from any destination
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;

	squeeze_io_top #(
		.FIFO_DEPTH (squeeze_io_pkg::FIFO_DEPTH),
		.MEM_WORDS  (squeeze_io_pkg::MEM_WORDS)
	) i_dut (
		.okClk      (okClk),
		.reset      (reset),
		.fifo_reset (fifo_reset),
		.core_reset (core_reset),
		.writes_en  (writes_en),
		.reads_en   (reads_en),
		.op_en      (op_en),
		.op_run     (op_run),
		.pi_write   (pi_write),
		.pi_data    (pi_data),
		.pi_ready   (pi_ready),
		.po_read    (po_read),
		.po_data    (po_data),
		.po_ready   (po_ready),
		.cmd_rd_en  (cmd_rd_en),
		.cmd        (cmd),
		.cmd_empty  (cmd_empty),
		.data_rd_en (data_rd_en),
		.data_0     (data_0),
		.data_empty (data_empty)
	);

	always #20 okClk = ~okClk;  // 40 ns period

	function automatic logic [31:0] lcg_next(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// n-th word of the host stream, replayed from the seed
	function automatic logic [31:0] expected_word(input int n);
		logic [31:0] s;
		s = SEED;
		for (int i = 0; i <= n; i++) begin
			s = lcg_next(s);
		end
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("%s: pass", name);
		end else begin
			$display("%s: fail, %0d errors", name, errors - errors_before);
		end
	endtask

	// ------------------------------------------------------------
	// host side drivers
	// ------------------------------------------------------------
	task automatic send_words(input int n);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(posedge okClk);
			if (pi_ready) begin
				gen_state = lcg_next(gen_state);
				pi_write <= 1'b1;
				pi_data  <= gen_state;
				sent++;
				wr_idx++;
			end else begin
				pi_write <= 1'b0;  // host waits for the throttle
			end
		end
		@(posedge okClk);
		pi_write <= 1'b0;
	endtask

	task automatic fill_until_throttle(output int n);
		logic done;
		n = 0;
		done = 1'b0;
		while (!done) begin
			@(posedge okClk);
			if (pi_ready && n < squeeze_io_pkg::FIFO_DEPTH) begin
				gen_state = lcg_next(gen_state);
				pi_write <= 1'b1;
				pi_data  <= gen_state;
				n++;
				wr_idx++;
			end else begin
				pi_write <= 1'b0;
				done = 1'b1;
			end
		end
	endtask

	// pops whole blocks, one word every gap cycles
	task automatic read_pipe(input int n, input int gap);
		for (int b = 0; b < n / BLOCK; b++) begin
			while (!po_ready) begin
				@(posedge okClk);
			end
			for (int w = 0; w < BLOCK; w++) begin
				@(posedge okClk);
				po_read <= 1'b1;
				repeat (gap - 1) begin
					@(posedge okClk);
					po_read <= 1'b0;
				end
			end
			@(posedge okClk);
			po_read <= 1'b0;
			repeat (2) @(posedge okClk);  // po_ready lags the count by two edges
		end
	endtask

	// one pop every other cycle so the empty flag is always current
	task automatic drain_fifo(input logic use_data, input int n);
		int   got;
		logic empty_now;
		got = 0;
		while (got < n) begin
			@(posedge okClk);
			empty_now = use_data ? data_empty : cmd_empty;
			if (!empty_now) begin
				if (use_data) begin
					data_rd_en <= 1'b1;
				end else begin
					cmd_rd_en <= 1'b1;
				end
				got++;
				@(posedge okClk);
				cmd_rd_en  <= 1'b0;
				data_rd_en <= 1'b0;
			end
		end
	endtask

	// ------------------------------------------------------------
	// compare and timeout
	// ------------------------------------------------------------
	always @(negedge okClk) begin
		if (po_read) begin
			check_value("po_data", po_data, expected_word(rd_idx));
			rd_idx++;
		end
		if (cmd_rd_en) begin
			check_value("cmd", cmd, expected_word(rd_idx));
			rd_idx++;
		end
		if (data_rd_en) begin
			check_value("data_0", data_0, expected_word(rd_idx));
			rd_idx++;
		end
	end

	always @(posedge okClk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d words read back of %0d driven",
				cycles, rd_idx, wr_idx);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin : main
		int   err0;
		int   n_fill;
		int   n_expect;
		logic seen;
		okClk      = 1'b0;
		reset      = 1'b1;
		fifo_reset = 1'b0;
		core_reset = 1'b0;
		writes_en  = 1'b0;
		reads_en   = 1'b0;
		op_en      = 1'b0;
		op_run     = 1'b0;
		pi_write   = 1'b0;
		pi_data    = '0;
		po_read    = 1'b0;
		cmd_rd_en  = 1'b0;
		data_rd_en = 1'b0;
		gen_state  = SEED;
		repeat (8) @(posedge okClk);
		reset <= 1'b0;

		// ------------------------------------------------------------
		// reset state
		// ------------------------------------------------------------
		err0 = errors;
		@(negedge okClk);
		check_value("po_ready", 32'(po_ready), 32'd0);
		check_value("cmd_empty", 32'(cmd_empty), 32'd1);
		check_value("data_empty", 32'(data_empty), 32'd1);
		seen = 1'b0;
		repeat (2) begin
			@(negedge okClk);
			seen = seen | pi_ready;
		end
		check_value("pi_ready", 32'(seen), 32'd1);
		finish_test("test 1 reset state", err0);

		// loopback through the store to pipe out
		err0 = errors;
		@(posedge okClk);
		op_en     <= 1'b0;
		op_run    <= 1'b0;
		writes_en <= 1'b1;
		reads_en  <= 1'b1;
		send_words(2 * BLOCK);
		read_pipe(2 * BLOCK, 1);
		@(negedge okClk);
		check_value("po_ready", 32'(po_ready), 32'd0);
		check_value("cmd_empty", 32'(cmd_empty), 32'd1);
		check_value("data_empty", 32'(data_empty), 32'd1);
		finish_test("test 2 loopback", err0);

		// command route
		err0 = errors;
		@(posedge okClk);
		op_en  <= 1'b1;
		op_run <= 1'b0;
		send_words(BLOCK);
		drain_fifo(1'b0, BLOCK);
		@(negedge okClk);
		check_value("cmd_empty", 32'(cmd_empty), 32'd1);
		check_value("po_ready", 32'(po_ready), 32'd0);
		check_value("data_empty", 32'(data_empty), 32'd1);
		finish_test("test 3 command route", err0);

		// data route
		err0 = errors;
		@(posedge okClk);
		op_en  <= 1'b1;
		op_run <= 1'b1;
		send_words(BLOCK);
		drain_fifo(1'b1, BLOCK);
		@(negedge okClk);
		check_value("data_empty", 32'(data_empty), 32'd1);
		check_value("po_ready", 32'(po_ready), 32'd0);
		check_value("cmd_empty", 32'(cmd_empty), 32'd1);
		finish_test("test 4 data route", err0);

		// ------------------------------------------------------------
		// throttle and back-pressure
		// ------------------------------------------------------------
		err0 = errors;
		@(posedge okClk);
		writes_en <= 1'b0;
		reads_en  <= 1'b0;
		op_en     <= 1'b0;
		op_run    <= 1'b0;
		fill_until_throttle(n_fill);
		if (n_fill < N_MIN || n_fill > N_MAX) begin
			errors++;
			$display("pi_ready fell after %0d words, expected %0d to %0d",
				n_fill, N_MIN, N_MAX);
		end
		n_expect = (n_fill / BLOCK) * BLOCK;  // partial block stays queued
		@(posedge okClk);
		writes_en <= 1'b1;
		reads_en  <= 1'b1;
		read_pipe(n_expect, 4);
		repeat (300) @(posedge okClk);  // room for a stray block to appear
		@(negedge okClk);
		check_value("po_ready", 32'(po_ready), 32'd0);
		$display("throttle fell after %0d words, %0d moved", n_fill, n_expect);
		finish_test("test 5 throttle", err0);

		$display("%0d checks, %0d errors, %0d words driven, %0d read back",
			checks, errors, wr_idx, rd_idx);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/squeeze_io_pkg.sv
rtl/sync_fifo.sv
rtl/host_pipes.sv
rtl/word_store.sv
rtl/block_dma.sv
rtl/dest_router.sv
rtl/squeeze_io_top.sv
verif/tb_squeeze_io.sv
